// File: hdl/tlb_pkg.sv
package tlb_pkg;

    // entry count and derived index width
    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = $clog2(TLB_NUM);

    // virtual page pair number, va[31:13]
    typedef logic [18:0] vppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  mat_t;
    typedef logic [1:0]  plv_t;
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;
    typedef logic [4:0]  inv_op_t;

    // 4K pages, anything else is a huge page
    localparam ps_t PS_4K = 6'd12;

    // huge page compares vppn[18:9], half picked by vppn[8]
    localparam int HUGE_CMP_LSB     = 9;
    localparam int ODD_SEL_HUGE_BIT = 8;

    // invalidate operation codes
    localparam inv_op_t INV_ALL0         = 5'd0;
    localparam inv_op_t INV_ALL1         = 5'd1;
    localparam inv_op_t INV_GLOBAL       = 5'd2;
    localparam inv_op_t INV_NONGLOBAL    = 5'd3;
    localparam inv_op_t INV_ASID         = 5'd4;
    localparam inv_op_t INV_ASID_VA      = 5'd5;
    localparam inv_op_t INV_G_OR_ASID_VA = 5'd6;

endpackage

// File: hdl/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array (
    input  logic               clk,
    input  logic               reset,

    // write port
    input  logic               we,
    input  tlb_pkg::tlb_idx_t  w_index,
    input  tlb_pkg::vppn_t     w_vppn,
    input  tlb_pkg::asid_t     w_asid,
    input  logic               w_g,
    input  tlb_pkg::ps_t       w_ps,
    input  logic               w_e,
    input  logic               w_v0,
    input  logic               w_d0,
    input  tlb_pkg::mat_t      w_mat0,
    input  tlb_pkg::plv_t      w_plv0,
    input  tlb_pkg::ppn_t      w_ppn0,
    input  logic               w_v1,
    input  logic               w_d1,
    input  tlb_pkg::mat_t      w_mat1,
    input  tlb_pkg::plv_t      w_plv1,
    input  tlb_pkg::ppn_t      w_ppn1,

    // read port
    input  tlb_pkg::tlb_idx_t  r_index,
    output tlb_pkg::vppn_t     r_vppn,
    output tlb_pkg::asid_t     r_asid,
    output logic               r_g,
    output tlb_pkg::ps_t       r_ps,
    output logic               r_e,
    output logic               r_v0,
    output logic               r_d0,
    output tlb_pkg::mat_t      r_mat0,
    output tlb_pkg::plv_t      r_plv0,
    output tlb_pkg::ppn_t      r_ppn0,
    output logic               r_v1,
    output logic               r_d1,
    output tlb_pkg::mat_t      r_mat1,
    output tlb_pkg::plv_t      r_plv1,
    output tlb_pkg::ppn_t      r_ppn1,

    // entries to be cleared this cycle
    input  logic [tlb_pkg::TLB_NUM-1:0] inv_kill,

    // entry contents for lookup and invalidate
    output tlb_pkg::vppn_t     entry_vppn [tlb_pkg::TLB_NUM],
    output tlb_pkg::asid_t     entry_asid [tlb_pkg::TLB_NUM],
    output logic               entry_g    [tlb_pkg::TLB_NUM],
    output logic               entry_e    [tlb_pkg::TLB_NUM],
    output tlb_pkg::ps_t       entry_ps   [tlb_pkg::TLB_NUM],
    output tlb_pkg::ppn_t      entry_ppn0 [tlb_pkg::TLB_NUM],
    output logic               entry_v0   [tlb_pkg::TLB_NUM],
    output logic               entry_d0   [tlb_pkg::TLB_NUM],
    output tlb_pkg::mat_t      entry_mat0 [tlb_pkg::TLB_NUM],
    output tlb_pkg::plv_t      entry_plv0 [tlb_pkg::TLB_NUM],
    output tlb_pkg::ppn_t      entry_ppn1 [tlb_pkg::TLB_NUM],
    output logic               entry_v1   [tlb_pkg::TLB_NUM],
    output logic               entry_d1   [tlb_pkg::TLB_NUM],
    output tlb_pkg::mat_t      entry_mat1 [tlb_pkg::TLB_NUM],
    output tlb_pkg::plv_t      entry_plv1 [tlb_pkg::TLB_NUM]
);

    import tlb_pkg::*;

    // payload fields, no reset
    always_ff @(posedge clk) begin
        if (we) begin
            entry_vppn[w_index] <= w_vppn;
            entry_asid[w_index] <= w_asid;
            entry_g[w_index]    <= w_g;
            entry_ps[w_index]   <= w_ps;
            entry_ppn0[w_index] <= w_ppn0;
            entry_v0[w_index]   <= w_v0;
            entry_d0[w_index]   <= w_d0;
            entry_mat0[w_index] <= w_mat0;
            entry_plv0[w_index] <= w_plv0;
            entry_ppn1[w_index] <= w_ppn1;
            entry_v1[w_index]   <= w_v1;
            entry_d1[w_index]   <= w_d1;
            entry_mat1[w_index] <= w_mat1;
            entry_plv1[w_index] <= w_plv1;
        end
    end

    // enables: write at own index beats the kill mask
    always_ff @(posedge clk) begin
        for (int i = 0; i < TLB_NUM; i++) begin
            if (reset) begin
                entry_e[i] <= 1'b0;
            end else if (we && (w_index == tlb_idx_t'(i))) begin
                entry_e[i] <= w_e;
            end else if (inv_kill[i]) begin
                entry_e[i] <= 1'b0;
            end
        end
    end

    assign r_vppn = entry_vppn[r_index];
    assign r_asid = entry_asid[r_index];
    assign r_g    = entry_g[r_index];
    assign r_ps   = entry_ps[r_index];
    assign r_e    = entry_e[r_index];
    assign r_v0   = entry_v0[r_index];
    assign r_d0   = entry_d0[r_index];
    assign r_mat0 = entry_mat0[r_index];
    assign r_plv0 = entry_plv0[r_index];
    assign r_ppn0 = entry_ppn0[r_index];
    assign r_v1   = entry_v1[r_index];
    assign r_d1   = entry_d1[r_index];
    assign r_mat1 = entry_mat1[r_index];
    assign r_plv1 = entry_plv1[r_index];
    assign r_ppn1 = entry_ppn1[r_index];

endmodule

// File: hdl/tlb_search.sv
`timescale 1ns/1ps

module tlb_search (
    input  logic               clk,
    input  logic               reset,

    // lookup request
    input  logic               valid,
    input  tlb_pkg::vppn_t     vppn,
    input  tlb_pkg::asid_t     asid,
    input  logic               odd_page,

    // entry contents
    input  tlb_pkg::vppn_t     entry_vppn [tlb_pkg::TLB_NUM],
    input  tlb_pkg::asid_t     entry_asid [tlb_pkg::TLB_NUM],
    input  logic               entry_g    [tlb_pkg::TLB_NUM],
    input  logic               entry_e    [tlb_pkg::TLB_NUM],
    input  tlb_pkg::ps_t       entry_ps   [tlb_pkg::TLB_NUM],
    input  tlb_pkg::ppn_t      entry_ppn0 [tlb_pkg::TLB_NUM],
    input  logic               entry_v0   [tlb_pkg::TLB_NUM],
    input  logic               entry_d0   [tlb_pkg::TLB_NUM],
    input  tlb_pkg::mat_t      entry_mat0 [tlb_pkg::TLB_NUM],
    input  tlb_pkg::plv_t      entry_plv0 [tlb_pkg::TLB_NUM],
    input  tlb_pkg::ppn_t      entry_ppn1 [tlb_pkg::TLB_NUM],
    input  logic               entry_v1   [tlb_pkg::TLB_NUM],
    input  logic               entry_d1   [tlb_pkg::TLB_NUM],
    input  tlb_pkg::mat_t      entry_mat1 [tlb_pkg::TLB_NUM],
    input  tlb_pkg::plv_t      entry_plv1 [tlb_pkg::TLB_NUM],

    // lookup result
    output logic               found,
    output tlb_pkg::tlb_idx_t  index,
    output tlb_pkg::ps_t       ps,
    output tlb_pkg::ppn_t      ppn,
    output logic               v,
    output logic               d,
    output tlb_pkg::mat_t      mat,
    output tlb_pkg::plv_t      plv
);

    import tlb_pkg::*;

    logic [TLB_NUM-1:0] match_d;
    logic [TLB_NUM-1:0] match_q;
    logic [TLB_NUM-1:0] odd_d;
    logic [TLB_NUM-1:0] odd_q;
    tlb_idx_t           hit_idx;
    logic               hit_odd;

    // per-entry compare against the request
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            if (entry_ps[i] == PS_4K) begin
                match_d[i] = entry_e[i] && (entry_g[i] || (entry_asid[i] == asid)) &&
                             (entry_vppn[i] == vppn);
                odd_d[i]   = odd_page;
            end else begin
                match_d[i] = entry_e[i] && (entry_g[i] || (entry_asid[i] == asid)) &&
                             (entry_vppn[i][18:HUGE_CMP_LSB] == vppn[18:HUGE_CMP_LSB]);
                odd_d[i]   = vppn[ODD_SEL_HUGE_BIT];
            end
        end
    end

    // match held until the next request
    always_ff @(posedge clk) begin
        if (reset) begin
            match_q <= '0;
        end else if (valid) begin
            match_q <= match_d;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            odd_q <= odd_d;
        end
    end

    // lowest index wins
    always_comb begin
        hit_idx = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (match_q[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    assign hit_odd = odd_q[hit_idx];
    assign found   = |match_q;
    assign index   = hit_idx;

    // fields are read live from the array, zero on a miss
    assign ps  = found ? entry_ps[hit_idx] : '0;
    assign ppn = !found ? '0 : (hit_odd ? entry_ppn1[hit_idx] : entry_ppn0[hit_idx]);
    assign v   = found && (hit_odd ? entry_v1[hit_idx] : entry_v0[hit_idx]);
    assign d   = found && (hit_odd ? entry_d1[hit_idx] : entry_d0[hit_idx]);
    assign mat = !found ? '0 : (hit_odd ? entry_mat1[hit_idx] : entry_mat0[hit_idx]);
    assign plv = !found ? '0 : (hit_odd ? entry_plv1[hit_idx] : entry_plv0[hit_idx]);

endmodule

// File: hdl/tlb_inv_match.sv
`timescale 1ns/1ps

module tlb_inv_match (
    input  logic               tlbinv_en,
    input  tlb_pkg::inv_op_t   tlbinv_op,
    input  tlb_pkg::asid_t     tlbinv_asid,
    input  tlb_pkg::vppn_t     tlbinv_vpn,

    input  tlb_pkg::vppn_t     entry_vppn [tlb_pkg::TLB_NUM],
    input  tlb_pkg::asid_t     entry_asid [tlb_pkg::TLB_NUM],
    input  logic               entry_g    [tlb_pkg::TLB_NUM],
    input  tlb_pkg::ps_t       entry_ps   [tlb_pkg::TLB_NUM],

    output logic [tlb_pkg::TLB_NUM-1:0] inv_kill
);

    import tlb_pkg::*;

    always_comb begin
        logic asid_eq;
        logic va_eq;
        logic hit;
        asid_eq = 1'b0;
        va_eq   = 1'b0;
        hit     = 1'b0;
        for (int i = 0; i < TLB_NUM; i++) begin
            asid_eq = (entry_asid[i] == tlbinv_asid);
            // same page size rule as lookup
            if (entry_ps[i] == PS_4K) begin
                va_eq = (entry_vppn[i] == tlbinv_vpn);
            end else begin
                va_eq = (entry_vppn[i][18:HUGE_CMP_LSB] == tlbinv_vpn[18:HUGE_CMP_LSB]);
            end
            case (tlbinv_op)
                INV_ALL0, INV_ALL1: hit = 1'b1;
                INV_GLOBAL:         hit = entry_g[i];
                INV_NONGLOBAL:      hit = !entry_g[i];
                INV_ASID:           hit = !entry_g[i] && asid_eq;
                INV_ASID_VA:        hit = !entry_g[i] && asid_eq && va_eq;
                INV_G_OR_ASID_VA:   hit = (entry_g[i] || asid_eq) && va_eq;
                // codes 7 and up leave the table alone
                default:            hit = 1'b0;
            endcase
            inv_kill[i] = tlbinv_en && hit;
        end
    end

endmodule

// File: hdl/tlb_top.sv
`timescale 1ns/1ps

module tlb_top (
    input  logic               clk,
    input  logic               reset,

    // search port 0
    input  logic               s0_valid,
    input  tlb_pkg::vppn_t     s0_vppn,
    input  tlb_pkg::asid_t     s0_asid,
    input  logic               s0_odd_page,
    output logic               s0_found,
    output tlb_pkg::tlb_idx_t  s0_index,
    output tlb_pkg::ps_t       s0_ps,
    output tlb_pkg::ppn_t      s0_ppn,
    output logic               s0_v,
    output logic               s0_d,
    output tlb_pkg::mat_t      s0_mat,
    output tlb_pkg::plv_t      s0_plv,

    // search port 1
    input  logic               s1_valid,
    input  tlb_pkg::vppn_t     s1_vppn,
    input  tlb_pkg::asid_t     s1_asid,
    input  logic               s1_odd_page,
    output logic               s1_found,
    output tlb_pkg::tlb_idx_t  s1_index,
    output tlb_pkg::ps_t       s1_ps,
    output tlb_pkg::ppn_t      s1_ppn,
    output logic               s1_v,
    output logic               s1_d,
    output tlb_pkg::mat_t      s1_mat,
    output tlb_pkg::plv_t      s1_plv,

    // write port
    input  logic               we,
    input  tlb_pkg::tlb_idx_t  w_index,
    input  tlb_pkg::vppn_t     w_vppn,
    input  tlb_pkg::asid_t     w_asid,
    input  logic               w_g,
    input  tlb_pkg::ps_t       w_ps,
    input  logic               w_e,
    input  logic               w_v0,
    input  logic               w_d0,
    input  tlb_pkg::mat_t      w_mat0,
    input  tlb_pkg::plv_t      w_plv0,
    input  tlb_pkg::ppn_t      w_ppn0,
    input  logic               w_v1,
    input  logic               w_d1,
    input  tlb_pkg::mat_t      w_mat1,
    input  tlb_pkg::plv_t      w_plv1,
    input  tlb_pkg::ppn_t      w_ppn1,

    // read port
    input  tlb_pkg::tlb_idx_t  r_index,
    output tlb_pkg::vppn_t     r_vppn,
    output tlb_pkg::asid_t     r_asid,
    output logic               r_g,
    output tlb_pkg::ps_t       r_ps,
    output logic               r_e,
    output logic               r_v0,
    output logic               r_d0,
    output tlb_pkg::mat_t      r_mat0,
    output tlb_pkg::plv_t      r_plv0,
    output tlb_pkg::ppn_t      r_ppn0,
    output logic               r_v1,
    output logic               r_d1,
    output tlb_pkg::mat_t      r_mat1,
    output tlb_pkg::plv_t      r_plv1,
    output tlb_pkg::ppn_t      r_ppn1,

    // invalidate port
    input  logic               tlbinv_en,
    input  tlb_pkg::inv_op_t   tlbinv_op,
    input  tlb_pkg::asid_t     tlbinv_asid,
    input  tlb_pkg::vppn_t     tlbinv_vpn
);

    import tlb_pkg::*;

    vppn_t  entry_vppn [TLB_NUM];
    asid_t  entry_asid [TLB_NUM];
    logic   entry_g    [TLB_NUM];
    logic   entry_e    [TLB_NUM];
    ps_t    entry_ps   [TLB_NUM];
    ppn_t   entry_ppn0 [TLB_NUM];
    logic   entry_v0   [TLB_NUM];
    logic   entry_d0   [TLB_NUM];
    mat_t   entry_mat0 [TLB_NUM];
    plv_t   entry_plv0 [TLB_NUM];
    ppn_t   entry_ppn1 [TLB_NUM];
    logic   entry_v1   [TLB_NUM];
    logic   entry_d1   [TLB_NUM];
    mat_t   entry_mat1 [TLB_NUM];
    plv_t   entry_plv1 [TLB_NUM];

    logic [TLB_NUM-1:0] inv_kill;

    tlb_entry_array u_array (
        .clk        (clk),
        .reset      (reset),
        .we         (we),
        .w_index    (w_index),
        .w_vppn     (w_vppn),
        .w_asid     (w_asid),
        .w_g        (w_g),
        .w_ps       (w_ps),
        .w_e        (w_e),
        .w_v0       (w_v0),
        .w_d0       (w_d0),
        .w_mat0     (w_mat0),
        .w_plv0     (w_plv0),
        .w_ppn0     (w_ppn0),
        .w_v1       (w_v1),
        .w_d1       (w_d1),
        .w_mat1     (w_mat1),
        .w_plv1     (w_plv1),
        .w_ppn1     (w_ppn1),
        .r_index    (r_index),
        .r_vppn     (r_vppn),
        .r_asid     (r_asid),
        .r_g        (r_g),
        .r_ps       (r_ps),
        .r_e        (r_e),
        .r_v0       (r_v0),
        .r_d0       (r_d0),
        .r_mat0     (r_mat0),
        .r_plv0     (r_plv0),
        .r_ppn0     (r_ppn0),
        .r_v1       (r_v1),
        .r_d1       (r_d1),
        .r_mat1     (r_mat1),
        .r_plv1     (r_plv1),
        .r_ppn1     (r_ppn1),
        .inv_kill   (inv_kill),
        .entry_vppn (entry_vppn),
        .entry_asid (entry_asid),
        .entry_g    (entry_g),
        .entry_e    (entry_e),
        .entry_ps   (entry_ps),
        .entry_ppn0 (entry_ppn0),
        .entry_v0   (entry_v0),
        .entry_d0   (entry_d0),
        .entry_mat0 (entry_mat0),
        .entry_plv0 (entry_plv0),
        .entry_ppn1 (entry_ppn1),
        .entry_v1   (entry_v1),
        .entry_d1   (entry_d1),
        .entry_mat1 (entry_mat1),
        .entry_plv1 (entry_plv1)
    );

    // two lookups side by side on the same entries
    tlb_search u_search0 (
        .clk(clk), .reset(reset),
        .valid(s0_valid), .vppn(s0_vppn), .asid(s0_asid), .odd_page(s0_odd_page),
        .entry_vppn(entry_vppn), .entry_asid(entry_asid), .entry_g(entry_g),
        .entry_e(entry_e), .entry_ps(entry_ps),
        .entry_ppn0(entry_ppn0), .entry_v0(entry_v0), .entry_d0(entry_d0),
        .entry_mat0(entry_mat0), .entry_plv0(entry_plv0),
        .entry_ppn1(entry_ppn1), .entry_v1(entry_v1), .entry_d1(entry_d1),
        .entry_mat1(entry_mat1), .entry_plv1(entry_plv1),
        .found(s0_found), .index(s0_index), .ps(s0_ps), .ppn(s0_ppn),
        .v(s0_v), .d(s0_d), .mat(s0_mat), .plv(s0_plv)
    );

    tlb_search u_search1 (
        .clk(clk), .reset(reset),
        .valid(s1_valid), .vppn(s1_vppn), .asid(s1_asid), .odd_page(s1_odd_page),
        .entry_vppn(entry_vppn), .entry_asid(entry_asid), .entry_g(entry_g),
        .entry_e(entry_e), .entry_ps(entry_ps),
        .entry_ppn0(entry_ppn0), .entry_v0(entry_v0), .entry_d0(entry_d0),
        .entry_mat0(entry_mat0), .entry_plv0(entry_plv0),
        .entry_ppn1(entry_ppn1), .entry_v1(entry_v1), .entry_d1(entry_d1),
        .entry_mat1(entry_mat1), .entry_plv1(entry_plv1),
        .found(s1_found), .index(s1_index), .ps(s1_ps), .ppn(s1_ppn),
        .v(s1_v), .d(s1_d), .mat(s1_mat), .plv(s1_plv)
    );

    tlb_inv_match u_inv (
        .tlbinv_en   (tlbinv_en),
        .tlbinv_op   (tlbinv_op),
        .tlbinv_asid (tlbinv_asid),
        .tlbinv_vpn  (tlbinv_vpn),
        .entry_vppn  (entry_vppn),
        .entry_asid  (entry_asid),
        .entry_g     (entry_g),
        .entry_ps    (entry_ps),
        .inv_kill    (inv_kill)
    );

endmodule

// File: verif/tlb_tb_assert.sv
`timescale 1ns/1ps

module tlb_tb_assert (
    input  logic               clk,
    input  logic               reset,
    input  logic               s0_found,
    input  tlb_pkg::tlb_idx_t  s0_index,
    input  logic               s1_found,
    input  tlb_pkg::tlb_idx_t  s1_index,
    input  logic               we,
    input  logic               tlbinv_en,
    input  tlb_pkg::inv_op_t   tlbinv_op,
    input  logic               entry_e [tlb_pkg::TLB_NUM]
);

    import tlb_pkg::*;

    logic [TLB_NUM-1:0] e_vec;

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            e_vec[i] = entry_e[i];
        end
    end

    // lookups come out of reset empty
    assert property (@(posedge clk) reset |=> (!s0_found && !s1_found))
        else $error("search port reports a hit right after reset");

    // index inside the table on a hit and zero on a miss
    assert property (@(posedge clk) disable iff (reset)
        int'(s0_index) < (s0_found ? TLB_NUM : 1))
        else $error("s0 index outside the table or nonzero on a miss");

    assert property (@(posedge clk) disable iff (reset)
        int'(s1_index) < (s1_found ? TLB_NUM : 1))
        else $error("s1 index outside the table or nonzero on a miss");

    // full flush without a write
    assert property (@(posedge clk) disable iff (reset)
        (tlbinv_en && !we && (tlbinv_op == INV_ALL0 || tlbinv_op == INV_ALL1))
        |=> (e_vec == '0))
        else $error("entries still enabled after a full invalidate");

endmodule

bind tlb_top tlb_tb_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .s0_found  (s0_found),
    .s0_index  (s0_index),
    .s1_found  (s1_found),
    .s1_index  (s1_index),
    .we        (we),
    .tlbinv_en (tlbinv_en),
    .tlbinv_op (tlbinv_op),
    .entry_e   (entry_e)
);

// File: verif/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb;

    import tlb_pkg::*;

    localparam logic [2:0]  WR         = 3'd0;
    localparam logic [2:0]  INV        = 3'd1;
    localparam logic [2:0]  WRINV      = 3'd2;
    localparam logic [2:0]  SRCH       = 3'd3;
    localparam logic [2:0]  RD         = 3'd4;
    localparam ps_t         PS_2M      = 6'd21;
    localparam int          EDGE_LIMIT = 8;

    // invalidate sweep over entries 0..5 with one bit or asid slot each
    localparam vppn_t       SWEEP_VA   = 19'h31200;
    localparam logic [5:0]  SWEEP_G    = 6'b010010;
    localparam logic [5:0]  SWEEP_HUGE = 6'b110000;
    localparam logic [11:0] SWEEP_SLOT = 12'b00_10_01_00_01_00;

    typedef struct packed {
        ppn_t ppn;
        logic v;
        logic d;
        mat_t mat;
        plv_t plv;
    } half_t;

    typedef struct packed {
        vppn_t vppn;
        asid_t asid;
        logic  g;
        ps_t   ps;
        half_t h0;
        half_t h1;
    } entry_t;

    // e is w_e or the expected e of a read
    // idx is the expected index of a search
    typedef struct packed {
        logic [2:0] kind;
        tlb_idx_t   idx;
        vppn_t      vppn;
        logic [1:0] aslot;
        logic       g;
        ps_t        ps;
        logic       e;
        logic       odd;
        inv_op_t    op;
        logic       found;
    } step_t;

    logic     clk, reset, we, tlbinv_en;
    logic     s0_valid, s0_odd_page, s0_found, s0_v, s0_d;
    logic     s1_valid, s1_odd_page, s1_found, s1_v, s1_d;
    logic     w_g, w_e, w_v0, w_d0, w_v1, w_d1;
    logic     r_g, r_e, r_v0, r_d0, r_v1, r_d1;
    vppn_t    s0_vppn, s1_vppn, w_vppn, r_vppn, tlbinv_vpn;
    asid_t    s0_asid, s1_asid, w_asid, r_asid, tlbinv_asid;
    tlb_idx_t s0_index, s1_index, w_index, r_index;
    ps_t      s0_ps, s1_ps, w_ps, r_ps;
    ppn_t     s0_ppn, s1_ppn, w_ppn0, w_ppn1, r_ppn0, r_ppn1;
    mat_t     s0_mat, s1_mat, w_mat0, w_mat1, r_mat0, r_mat1;
    plv_t     s0_plv, s1_plv, w_plv0, w_plv1, r_plv0, r_plv1;
    inv_op_t  tlbinv_op;

    step_t  steps [$];
    entry_t shadow [TLB_NUM];
    asid_t  asid_tab [4];
    int     seed = 32'ha7c7;
    int     checks;
    int     errors;

    tlb_top DUT (.*);

    always #4 clk = ~clk;

    function automatic half_t rand_half();
        logic [31:0] r;
        r = $random(seed);
        return r[25:0];
    endfunction

    function automatic logic va_hit(input vppn_t ent, input ps_t ps, input vppn_t va);
        if (ps == PS_4K) begin
            return ent == va;
        end
        return ent[18:HUGE_CMP_LSB] == va[18:HUGE_CMP_LSB];
    endfunction

    function automatic vppn_t sweep_vppn(input int k);
        if (SWEEP_HUGE[k]) begin
            return SWEEP_VA ^ 19'h1f;
        end
        return (k == 2) ? SWEEP_VA + 19'd1 : SWEEP_VA;
    endfunction

    function automatic ps_t sweep_ps(input int k);
        return SWEEP_HUGE[k] ? PS_2M : PS_4K;
    endfunction

    // kill rule for sweep entry k against asid slot 0 and SWEEP_VA
    function automatic logic inv_hits(input int k, input inv_op_t op);
        logic g;
        logic asid_eq;
        logic va_eq;
        g       = SWEEP_G[k];
        asid_eq = (SWEEP_SLOT[2*k +: 2] == 2'd0);
        va_eq   = va_hit(sweep_vppn(k), sweep_ps(k), SWEEP_VA);
        case (op)
            INV_ALL0, INV_ALL1: return 1'b1;
            INV_GLOBAL:         return g;
            INV_NONGLOBAL:      return !g;
            INV_ASID:           return !g && asid_eq;
            INV_ASID_VA:        return !g && asid_eq && va_eq;
            INV_G_OR_ASID_VA:   return (g || asid_eq) && va_eq;
            default:            return 1'b0;
        endcase
    endfunction

    task automatic add_step(input logic [2:0] kind, input tlb_idx_t idx, input vppn_t vppn,
                            input logic [1:0] aslot, input logic g, input ps_t ps,
                            input logic e, input logic odd, input inv_op_t op,
                            input logic found);
        steps.push_back('{kind, idx, vppn, aslot, g, ps, e, odd, op, found});
    endtask

    task automatic build_table();
        int   first;
        logic alive;
        add_step(SRCH, 4'd0, 19'h12345, 2'd0, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b0);
        add_step(WR, 4'd3, 19'h12345, 2'd0, 1'b0, PS_4K, 1'b1, 1'b0, INV_ALL0, 1'b0);
        add_step(WR, 4'd5, 19'h12345, 2'd1, 1'b1, PS_4K, 1'b1, 1'b0, INV_ALL0, 1'b0);
        add_step(WR, 4'd7, 19'h2a400, 2'd2, 1'b0, PS_2M, 1'b1, 1'b0, INV_ALL0, 1'b0);
        add_step(WR, 4'd9, 19'h0abcd, 2'd3, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b0);
        add_step(RD, 4'd3, 19'h0, 2'd0, 1'b0, PS_4K, 1'b1, 1'b0, INV_ALL0, 1'b0);
        add_step(RD, 4'd5, 19'h0, 2'd0, 1'b0, PS_4K, 1'b1, 1'b0, INV_ALL0, 1'b0);
        add_step(RD, 4'd7, 19'h0, 2'd0, 1'b0, PS_4K, 1'b1, 1'b0, INV_ALL0, 1'b0);
        add_step(RD, 4'd9, 19'h0, 2'd0, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b0);
        // 3 is private to slot 0 and 5 is global so both match
        add_step(SRCH, 4'd3, 19'h12345, 2'd0, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b1);
        add_step(SRCH, 4'd5, 19'h12345, 2'd1, 1'b0, PS_4K, 1'b0, 1'b1, INV_ALL0, 1'b1);
        add_step(SRCH, 4'd7, 19'h2a4ff, 2'd2, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b1);
        add_step(SRCH, 4'd7, 19'h2a5ff, 2'd2, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b1);
        add_step(SRCH, 4'd0, 19'h2a5ff, 2'd0, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b0);
        add_step(SRCH, 4'd0, 19'h2a200, 2'd2, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b0);
        add_step(SRCH, 4'd0, 19'h0abcd, 2'd3, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b0);
        add_step(WRINV, 4'd9, 19'h0abcd, 2'd3, 1'b0, PS_4K, 1'b1, 1'b0, INV_ALL1, 1'b0);
        add_step(RD, 4'd3, 19'h0, 2'd0, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b0);
        add_step(RD, 4'd9, 19'h0, 2'd0, 1'b0, PS_4K, 1'b1, 1'b0, INV_ALL0, 1'b0);
        add_step(SRCH, 4'd9, 19'h0abcd, 2'd3, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b1);
        add_step(SRCH, 4'd0, 19'h12345, 2'd1, 1'b0, PS_4K, 1'b0, 1'b0, INV_ALL0, 1'b0);
        // every invalidate code on a freshly written set
        for (int op = 0; op < 8; op++) begin
            first = -1;
            for (int k = 0; k < 6; k++) begin
                add_step(WR, tlb_idx_t'(k), sweep_vppn(k), SWEEP_SLOT[2*k +: 2], SWEEP_G[k],
                         sweep_ps(k), 1'b1, 1'b0, INV_ALL0, 1'b0);
            end
            add_step(INV, 4'd0, SWEEP_VA, 2'd0, 1'b0, PS_4K, 1'b0, 1'b0, inv_op_t'(op), 1'b0);
            for (int k = 0; k < 6; k++) begin
                alive = !inv_hits(k, inv_op_t'(op));
                add_step(RD, tlb_idx_t'(k), SWEEP_VA, 2'd0, 1'b0, PS_4K, alive, 1'b0,
                         INV_ALL0, 1'b0);
                if (alive && first < 0 && (SWEEP_G[k] || SWEEP_SLOT[2*k +: 2] == 2'd0) &&
                        va_hit(sweep_vppn(k), sweep_ps(k), SWEEP_VA)) begin
                    first = k;
                end
            end
            add_step(SRCH, tlb_idx_t'(first < 0 ? 0 : first), SWEEP_VA, 2'd0, 1'b0, PS_4K,
                     1'b0, 1'b0, INV_ALL0, first >= 0);
        end
    endtask

    task automatic clear_inputs();
        {we, tlbinv_en, s0_valid, s1_valid} = '0;
        {s0_vppn, s0_asid, s0_odd_page, s1_vppn, s1_asid, s1_odd_page} = '0;
        {w_index, w_vppn, w_asid, w_g, w_ps, w_e} = '0;
        {w_v0, w_d0, w_mat0, w_plv0, w_ppn0, w_v1, w_d1, w_mat1, w_plv1, w_ppn1} = '0;
        {r_index, tlbinv_op, tlbinv_asid, tlbinv_vpn} = '0;
    endtask

    task automatic check_search(input int port, input logic exp_found, input tlb_idx_t exp_idx,
                                input ps_t exp_ps, input ppn_t exp_ppn, input logic exp_v,
                                input logic exp_d, input mat_t exp_mat, input plv_t exp_plv);
        logic     act_found;
        tlb_idx_t act_idx;
        ps_t      act_ps;
        ppn_t     act_ppn;
        logic     act_v;
        logic     act_d;
        mat_t     act_mat;
        plv_t     act_plv;
        if (port == 0) begin
            act_found = s0_found;
            act_idx   = s0_index;
            act_ps    = s0_ps;
            act_ppn   = s0_ppn;
            act_v     = s0_v;
            act_d     = s0_d;
            act_mat   = s0_mat;
            act_plv   = s0_plv;
        end else begin
            act_found = s1_found;
            act_idx   = s1_index;
            act_ps    = s1_ps;
            act_ppn   = s1_ppn;
            act_v     = s1_v;
            act_d     = s1_d;
            act_mat   = s1_mat;
            act_plv   = s1_plv;
        end
        checks++;
        if (act_found !== exp_found || act_idx !== exp_idx) begin
            errors++;
            $display("mismatch at %0t: s%0d found %b index %0d, expected found %b index %0d",
                     $time, port, act_found, act_idx, exp_found, exp_idx);
        end
        if (act_ps !== exp_ps || act_ppn !== exp_ppn) begin
            errors++;
            $display("mismatch at %0t: s%0d ps %0d ppn %h, expected ps %0d ppn %h",
                     $time, port, act_ps, act_ppn, exp_ps, exp_ppn);
        end
        if ({act_v, act_d, act_mat, act_plv} !== {exp_v, exp_d, exp_mat, exp_plv}) begin
            errors++;
            $display("mismatch at %0t: s%0d v %b d %b mat %0d plv %0d, expected %b %b %0d %0d",
                     $time, port, act_v, act_d, act_mat, act_plv,
                     exp_v, exp_d, exp_mat, exp_plv);
        end
    endtask

    task automatic check_read(input tlb_idx_t idx, input logic exp_e, input entry_t exp_ent);
        entry_t act;
        act = {r_vppn, r_asid, r_g, r_ps, r_ppn0, r_v0, r_d0, r_mat0, r_plv0,
               r_ppn1, r_v1, r_d1, r_mat1, r_plv1};
        checks++;
        if (r_e !== exp_e) begin
            errors++;
            $display("mismatch at %0t: read %0d e %b, expected %b", $time, idx, r_e, exp_e);
        end
        if (act !== exp_ent) begin
            errors++;
            $display("mismatch at %0t: read %0d entry %h, expected %h",
                     $time, idx, act, exp_ent);
        end
    endtask

    // both search ports are sampled at the first edge with valid high
    task automatic wait_capture();
        int n;
        n = 0;
        @(posedge clk);
        while (!(s0_valid && s1_valid) && n < EDGE_LIMIT) begin
            n++;
            @(posedge clk);
        end
        if (n >= EDGE_LIMIT) begin
            $display("timeout: search request not captured within %0d cycles", EDGE_LIMIT);
            $display("Regression failed");
            $finish;
        end else begin
            #1;
        end
    endtask

    task automatic apply_step(input step_t s);
        half_t h0;
        half_t h1;
        half_t exp_h;
        ps_t   exp_ps;
        logic  odd_sel;
        if (s.kind == WR || s.kind == WRINV) begin
            h0 = rand_half();
            h1 = rand_half();
            we      = 1'b1;
            w_index = s.idx;
            w_vppn  = s.vppn;
            w_asid  = asid_tab[s.aslot];
            w_g     = s.g;
            w_ps    = s.ps;
            w_e     = s.e;
            {w_ppn0, w_v0, w_d0, w_mat0, w_plv0} = h0;
            {w_ppn1, w_v1, w_d1, w_mat1, w_plv1} = h1;
            shadow[s.idx] = '{s.vppn, asid_tab[s.aslot], s.g, s.ps, h0, h1};
        end
        if (s.kind == INV || s.kind == WRINV) begin
            tlbinv_en   = 1'b1;
            tlbinv_op   = s.op;
            tlbinv_asid = asid_tab[s.aslot];
            tlbinv_vpn  = s.vppn;
        end
        if (s.kind == RD) begin
            r_index = s.idx;
        end
        if (s.kind == SRCH) begin
            s0_valid    = 1'b1;
            s0_vppn     = s.vppn;
            s0_asid     = asid_tab[s.aslot];
            s0_odd_page = s.odd;
            s1_valid    = 1'b1;
            s1_vppn     = s.vppn;
            s1_asid     = asid_tab[s.aslot];
            s1_odd_page = !s.odd;
            wait_capture();
        end else begin
            @(posedge clk);
            #1;
        end
        {we, tlbinv_en, s0_valid, s1_valid} = '0;
        if (s.kind == RD) begin
            check_read(s.idx, s.e, shadow[s.idx]);
        end
        if (s.kind == SRCH) begin
            for (int p = 0; p < 2; p++) begin
                exp_ps = '0;
                exp_h  = '0;
                if (s.found) begin
                    exp_ps  = shadow[s.idx].ps;
                    odd_sel = (exp_ps == PS_4K) ? (s.odd ^ p[0]) : s.vppn[ODD_SEL_HUGE_BIT];
                    exp_h   = odd_sel ? shadow[s.idx].h1 : shadow[s.idx].h0;
                end
                check_search(p, s.found, s.idx, exp_ps, exp_h.ppn, exp_h.v, exp_h.d,
                             exp_h.mat, exp_h.plv);
            end
        end
    endtask

    initial begin
        logic [31:0] rnd;
        clk    = 1'b0;
        reset  = 1'b1;
        checks = 0;
        errors = 0;
        clear_inputs();
        // the low asid bits carry the slot number so all four differ
        for (int k = 0; k < 4; k++) begin
            rnd = $random(seed);
            asid_tab[k] = {rnd[9:2], k[1:0]};
        end
        build_table();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("steps: %0d, checks: %0d, errors: %0d", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
hdl/tlb_pkg.sv
hdl/tlb_entry_array.sv
hdl/tlb_search.sv
hdl/tlb_inv_match.sv
hdl/tlb_top.sv
verif/tlb_tb_assert.sv
verif/tlb_tb.sv

// File: Makefile
SIM = obj_dir/Vtlb_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert --top-module tlb_tb -f filelist.f -Mdir obj_dir
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
